// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rvCoreTb -f sim.f

output="$(./obj_dir/VrvCoreTb)" || { echo "$output"; exit 1; }
echo "$output"
if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

// File: sim.f
+incdir+verif
verilog/rvIsaPkg.sv
verilog/cpuCtrlPkg.sv
verilog/unifiedMemory.sv
verilog/instrFetch.sv
verilog/controlFsm.sv
verilog/registerFile.sv
verilog/execUnit.sv
verilog/writeBack.sv
verilog/rvCore.sv
verif/rvCoreTb.sv

// File: verif/rvCoreTests.svh
// instruction encoders, program loader and the directed tests of the RV32I core.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encoders
function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opOp};
endfunction

function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
endfunction

function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] encU(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference rules
function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic logic [31:0] rvAlu(logic [2:0] f3, logic alt, logic [31:0] a,
                                      logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'd0, $signed(a) < $signed(b)};
        3'd3:    return {31'd0, a < b};
        3'd4:    return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchRule(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
        f3Beq:   return a == b;
        f3Bne:   return a != b;
        f3Blt:   return $signed(a) < $signed(b);
        f3Bge:   return $signed(a) >= $signed(b);
        f3Bltu:  return a < b;
        f3Bgeu:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program building and running
function automatic logic [31:0] pcNow();
    return 32'(progQ.size() * 4);
endfunction

task automatic startTest(string name);
    currentTest = name;
    progQ.delete();
    expectQ.delete();
endtask

task automatic expectReg(logic [4:0] rd, logic [31:0] value);
    expectQ.push_back(regEvent(rd, value));
endtask

task automatic loadConst(logic [4:0] rd, logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;  // addi sign-extends the low part.
    progQ.push_back(encU(upper[31:12], rd, opLui));
    expectReg(rd, {upper[31:12], 12'd0});
    progQ.push_back(encI(value[11:0], rd, f3Add, rd, opOpImm));
    expectReg(rd, value);
endtask

task automatic endProgram();
    expectReg(5'd0, pcNow() + 32'd4);  // one link write to x0 per pass of the self loop.
    progQ.push_back(encJ(21'd0, 5'd0));
endtask

task automatic loadProgram();
    foreach (progQ[i]) begin
        @(posedge clk);
        loadEn   <= 1'b1;
        loadAddr <= i[addrW-1:0];
        loadData <= progQ[i];
    end
    @(posedge clk);
    loadEn <= 1'b0;
endtask

task automatic runProgram();
    int          errorsBefore;
    logic [67:0] loopEvent;
    errorsBefore = errorCount;
    loadProgram();
    compareValue("strobes while loading", 68'd0, 68'(eventQ.size()));
    @(posedge clk);
    run <= 1'b1;
    while (eventQ.size() < expectQ.size()) @(posedge clk);
    @(posedge clk);
    run <= 1'b0;
    repeat (6) @(posedge clk);  // one more loop pass, then fetch drops to idle.
    loopEvent = expectQ[$];
    foreach (expectQ[i]) begin
        compareValue($sformatf("event %0d", i), expectQ[i], eventQ.pop_front());
    end
    while (eventQ.size() > 0) begin
        compareValue("self loop", loopEvent, eventQ.pop_front());
    end
    testCount++;
    if (errorCount == errorsBefore) begin
        $display("%s: ok, %0d events", currentTest, expectQ.size());
    end else begin
        $display("%s: %0d mismatches", currentTest, errorCount - errorsBefore);
        testsFailed++;
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests
task automatic resetIdleTest();
    startTest("reset idle");
    compareValue("strobes after reset", 68'd0, 68'(eventQ.size()));
    progQ.push_back(encI(12'd5, 5'd0, f3Add, 5'd1, opOpImm));
    expectReg(5'd1, 32'd5);
    endProgram();
    runProgram();
endtask

task automatic aluTest();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [11:0] operand;
    logic [4:0]  shamt;
    logic [4:0]  rd;
    startTest("alu");
    a     = randomBits(32);
    b     = randomBits(32);
    imm   = 12'(randomBits(12));
    shamt = 5'(randomBits(5));
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    rd = 5'd3;
    for (int f = 0; f < 8; f++) begin
        progQ.push_back(encR(7'd0, 5'd2, 5'd1, 3'(f), rd));
        expectReg(rd, rvAlu(3'(f), 1'b0, a, b));
        rd++;
    end
    progQ.push_back(encR(7'h20, 5'd2, 5'd1, f3Add, rd));  // sub.
    expectReg(rd, rvAlu(f3Add, 1'b1, a, b));
    rd++;
    progQ.push_back(encR(7'h20, 5'd2, 5'd1, f3Srl, rd));  // sra.
    expectReg(rd, rvAlu(f3Srl, 1'b1, a, b));
    rd++;
    for (int f = 0; f < 8; f++) begin
        operand = (f == 1 || f == 5) ? {7'd0, shamt} : imm;
        progQ.push_back(encI(operand, 5'd1, 3'(f), rd, opOpImm));
        expectReg(rd, rvAlu(3'(f), 1'b0, a, sext12(operand)));
        rd++;
    end
    progQ.push_back(encI({7'h20, shamt}, 5'd1, f3Srl, rd, opOpImm));  // srai.
    expectReg(rd, rvAlu(f3Srl, 1'b1, a, {27'd0, shamt}));
    // the x0 write still shows on the port, later reads see zero.
    progQ.push_back(encR(7'd0, 5'd2, 5'd1, f3Add, 5'd0));
    expectReg(5'd0, a + b);
    progQ.push_back(encR(7'd0, 5'd1, 5'd0, f3Add, 5'd22));
    expectReg(5'd22, a);
    endProgram();
    runProgram();
endtask

task automatic upperTest();
    logic [19:0] u;
    startTest("upper immediate");
    u = 20'(randomBits(20));
    expectReg(5'd5, {u, 12'd0});
    progQ.push_back(encU(u, 5'd5, opLui));
    u = 20'(randomBits(20));
    expectReg(5'd6, pcNow() + {u, 12'd0});
    progQ.push_back(encU(u, 5'd6, opAuipc));
    u = 20'(randomBits(20));
    expectReg(5'd19, pcNow() + {u, 12'd0});
    progQ.push_back(encU(u, 5'd19, opAuipc));
    endProgram();
    runProgram();
endtask

task automatic memoryTest();
    logic [31:0] data;
    logic [31:0] base;
    logic [31:0] r;
    logic [11:0] off;
    startTest("store load");
    data = randomBits(32);
    r    = randomBits(9);
    base = 32'h200 | {24'd0, r[5:0], 2'b00};  // data area above the programs.
    off  = {7'd0, r[8:6], 2'b00};
    loadConst(5'd7, data);
    loadConst(5'd8, base);
    progQ.push_back(encS(off, 5'd7, 5'd8));
    expectQ.push_back(storeEvent(base + sext12(off), data));
    progQ.push_back(encI(off, 5'd8, 3'b010, 5'd9, opLoad));
    expectReg(5'd9, data);
    endProgram();
    runProgram();
endtask

task automatic branchTest();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [2:0]  kinds [6];
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] m;
    startTest("branch");
    a     = randomBits(32);
    r     = randomBits(31);
    b     = {~a[31], r[30:0]};  // signed and unsigned order differ.
    kinds = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
    loadConst(5'd10, a);
    loadConst(5'd11, b);
    for (int t = 0; t < 6; t++) begin
        for (int p = 0; p < 2; p++) begin
            if (kinds[t] == f3Beq || kinds[t] == f3Bne) begin
                rs1 = 5'd10;
                rs2 = (p == 0) ? 5'd10 : 5'd11;
            end else begin
                rs1 = (p == 0) ? 5'd10 : 5'd11;
                rs2 = (p == 0) ? 5'd11 : 5'd10;
            end
            m = 12'(32 + 4 * t + 2 * p);
            progQ.push_back(encB(13'd8, rs2, rs1, kinds[t]));
            progQ.push_back(encI(m, 5'd0, f3Add, 5'd12, opOpImm));  // skipped when taken.
            if (!branchRule(kinds[t], (rs1 == 5'd10) ? a : b, (rs2 == 5'd10) ? a : b)) begin
                expectReg(5'd12, {20'd0, m});
            end
            progQ.push_back(encI(m + 12'd1, 5'd0, f3Add, 5'd13, opOpImm));
            expectReg(5'd13, {20'd0, m + 12'd1});
        end
    end
    endProgram();
    runProgram();
endtask

task automatic jumpTest();
    logic [31:0] pcJump;
    logic [31:0] pcBase;
    startTest("jump");
    expectReg(5'd14, pcNow() + 32'd4);
    progQ.push_back(encJ(21'd12, 5'd14));
    progQ.push_back(encI(12'd1, 5'd0, f3Add, 5'd15, opOpImm));
    progQ.push_back(encI(12'd2, 5'd0, f3Add, 5'd15, opOpImm));
    pcBase = pcNow();
    expectReg(5'd16, pcBase);
    progQ.push_back(encU(20'd0, 5'd16, opAuipc));
    pcJump = pcNow();
    expectReg(5'd17, pcJump + 32'd4);
    // odd offset, the target lands on base plus 12 once bit 0 is cleared.
    progQ.push_back(encI(12'd13, 5'd16, 3'b000, 5'd17, opJalr));
    progQ.push_back(encI(12'd3, 5'd0, f3Add, 5'd15, opOpImm));
    progQ.push_back(encI(12'd7, 5'd0, f3Add, 5'd18, opOpImm));
    expectReg(5'd18, 32'd7);
    endProgram();
    runProgram();
endtask

// File: verif/rvCoreTb.sv
// testbench top with clock, reset, DUT, LFSR, check task, event monitor and timeout.
`timescale 1ns/1ps

module rvCoreTb import rvIsaPkg::*; ();

    localparam int memWords = 256;
    localparam int addrW    = $clog2(memWords);
    localparam int numTests = 6;
    // program words per test: reset, alu, upper, memory, branch, jump.
    localparam int progWords = 2 + 26 + 4 + 7 + 41 + 8;
    // five cycles per instruction, one per loaded word, plus settling per test.
    localparam int timeoutCycles = progWords * 6 + numTests * 12 + 100;

    logic              clk;
    logic              reset;
    logic              run;
    logic              loadEn;
    logic [addrW-1:0]  loadAddr;
    logic [31:0]       loadData;
    logic              regWrite;
    logic [4:0]        regAddr;
    logic [31:0]       regData;
    logic              storeValid;
    logic [31:0]       storeAddr;
    logic [31:0]       storeData;

    logic [31:0] lfsrState = 32'he9e9;
    logic [67:0] eventQ [$];   // {kind, address, data} as seen on the ports.
    logic [67:0] expectQ [$];
    logic [31:0] progQ [$];
    string       currentTest;
    int          checkCount  = 0;
    int          errorCount  = 0;
    int          testCount   = 0;
    int          testsFailed = 0;
    int          cycleCount  = 0;

    rvCore #(.memWords(memWords)) u_rvCore (
        .clk(clk), .reset(reset), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .regWrite(regWrite), .regAddr(regAddr), .regData(regData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random bits, galois LFSR stepped once per bit.
    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        logic        lsb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lsb       = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (lsb) begin
                lfsrState = lfsrState ^ 32'h80200003;  // x^32 + x^22 + x^2 + x + 1.
            end
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    function automatic logic [67:0] regEvent(logic [4:0] rd, logic [31:0] value);
        return {4'h1, 27'd0, rd, value};
    endfunction

    function automatic logic [67:0] storeEvent(logic [31:0] addr, logic [31:0] data);
        return {4'h2, addr, data};
    endfunction

    task automatic compareValue(string what, logic [67:0] expected, logic [67:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Error: %s, %s: expected %h, actual %h", currentTest, what, expected,
                     actual);
        end
    endtask

    `include "rvCoreTests.svh"

    // strobes are one cycle wide, so mid-cycle sampling sees each exactly once.
    always @(negedge clk) begin
        if (regWrite) begin
            eventQ.push_back(regEvent(regAddr, regData));
        end
        if (storeValid) begin
            eventQ.push_back(storeEvent(storeAddr, storeData));
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        resetIdleTest();
        aluTest();
        upperTest();
        memoryTest();
        branchTest();
        jumpTest();
        $display("%0d tests, %0d failed, %0d checks, %0d errors", testCount, testsFailed,
                 checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/controlFsm.sv
// multicycle control FSM, opcode decode into datapath enables and selects.
`timescale 1ns/1ps

module controlFsm import rvIsaPkg::*; import cpuCtrlPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    run,
    input  rvInstrT instr,
    input  logic    branchTaken,
    output logic    pcWrite,
    output logic    irWrite,
    output logic    mdrWrite,
    output logic    addrSel,
    output logic    memWrite,
    output aluSrcAT aluSrcA,
    output aluSrcBT aluSrcB,
    output aluOpT   aluOp,
    output logic    pcSel,
    output wbSelT   wbSel,
    output logic    regWriteEn
);

    ctrlStateT  state;
    ctrlStateT  nextState;
    logic [6:0] opcode;
    logic       knownOp;

    assign opcode  = instr.rType.opcode;
    assign knownOp = opcode inside {opLoad, opStore, opOp, opOpImm, opBranch,
                                    opJal, opJalr, opLui, opAuipc};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState  = state;
        pcWrite    = 1'b0;
        irWrite    = 1'b0;
        mdrWrite   = 1'b0;
        addrSel    = 1'b0;
        memWrite   = 1'b0;
        aluSrcA    = srcAPc;   // pc plus immediate unless told otherwise.
        aluSrcB    = srcBImm;
        aluOp      = aluAdd;
        pcSel      = 1'b0;
        wbSel      = wbAlu;
        regWriteEn = 1'b0;
        case (state)
            stIdle: begin
                // zero anded with anything clears the pc on the way out.
                aluSrcA = srcAZero;
                aluOp   = aluAnd;
                pcWrite = run;
                if (run) begin
                    nextState = stFetch;
                end
            end
            stFetch: begin
                irWrite   = run;
                nextState = run ? stDecode : stIdle;
            end
            stDecode: begin
                nextState = knownOp ? stExec : stFetch;  // branch target into aluOut.
            end
            stExec: begin
                nextState = stWb;
                case (opcode)
                    opOp: begin
                        aluSrcA = srcAReg;
                        aluSrcB = srcBReg;
                        aluOp   = aluFunct;
                    end
                    opOpImm: begin
                        aluSrcA = srcAReg;
                        aluOp   = aluFunct;
                    end
                    opLui:  aluSrcA = srcAZero;
                    opJalr: aluSrcA = srcAReg;
                    opLoad, opStore: begin
                        aluSrcA   = srcAReg;
                        addrSel   = 1'b1;  // address goes out as it is computed.
                        nextState = stMem;
                    end
                    opBranch: begin
                        pcWrite   = branchTaken;
                        pcSel     = 1'b1;
                        nextState = stFetch;
                    end
                    default: ;  // auipc and jal keep pc plus immediate.
                endcase
            end
            stMem: begin
                addrSel = 1'b1;
                pcSel   = 1'b1;
                if (opcode == opStore) begin
                    memWrite  = 1'b1;
                    nextState = stWb;  // wb puts the pc back on the shared port.
                end else begin
                    mdrWrite  = 1'b1;
                    nextState = stWb;
                end
            end
            stWb: begin
                regWriteEn = (opcode != opStore);
                nextState  = stFetch;
                if (opcode == opLoad) begin
                    wbSel = wbMem;
                end else if (opcode == opJal || opcode == opJalr) begin
                    wbSel   = wbPc4;
                    pcWrite = 1'b1;  // jump lands after the link is written.
                    pcSel   = 1'b1;
                end
            end
            default: nextState = stIdle;
        endcase
    end

    // the instruction word may only change in fetch.
    assert property (@(posedge clk) disable iff (reset) state != stFetch |=> $stable(instr))
        else $error("instruction register changed outside fetch");

endmodule

// File: verilog/cpuCtrlPkg.sv
// control FSM states, operand and write-back selects, ALU operation codes.
package cpuCtrlPkg;

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stDecode,
        stExec,
        stMem,
        stWb
    } ctrlStateT;

    typedef enum logic [1:0] {
        srcAReg,
        srcAPc,
        srcAZero
    } aluSrcAT;

    typedef enum logic {
        srcBReg,
        srcBImm
    } aluSrcBT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluFunct  // operation taken from funct3 of the instruction.
    } aluOpT;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPc4
    } wbSelT;

endpackage

// File: verilog/execUnit.sv
// immediate generator, operand registers, ALU, branch comparator, ALU output register.
`timescale 1ns/1ps

module execUnit import rvIsaPkg::*; import cpuCtrlPkg::*; (
    input  logic        clk,
    input  logic [31:0] pc,
    input  rvInstrT     instr,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    input  aluSrcAT     aluSrcA,
    input  aluSrcBT     aluSrcB,
    input  aluOpT       aluOp,
    input  logic        pcSel,
    output logic [31:0] aluOut,
    output logic [31:0] rs2Value,
    output logic [31:0] nextPc,
    output logic        branchTaken
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] imm;
    logic [31:0] rs1Value;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluResult;
    aluOpT       effOp;

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // immediates
    always_comb begin
        case (opcode)
            opStore:  imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
            opBranch: imm = {{20{instr.bType.imm12}}, instr.bType.imm11,
                             instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
            opLui, opAuipc: imm = {instr.uType.imm, 12'd0};
            opJal:    imm = {{12{instr.uType.imm[19]}}, instr.uType.imm[7:0],
                             instr.uType.imm[8], instr.uType.imm[18:9], 1'b0};
            default:  imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
        endcase
    end

    always_ff @(posedge clk) begin
        rs1Value <= rs1Data;
        rs2Value <= rs2Data;
        aluOut   <= {aluResult[31:1], aluResult[0] & (opcode != opJalr)};  // jalr drops bit 0.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu
    always_comb begin
        case (aluSrcA)
            srcAReg: opA = rs1Value;
            srcAPc:  opA = pc - 32'd4;  // pc has already stepped in fetch.
            default: opA = 32'd0;
        endcase
    end
    assign opB = (aluSrcB == srcBImm) ? imm : rs2Value;

    always_comb begin
        effOp = aluOp;
        if (aluOp == aluFunct) begin
            case (funct3)
                f3Add:   effOp = (opcode == opOp && instr.rType.funct7[5]) ? aluSub : aluAdd;
                f3Sll:   effOp = aluSll;
                f3Slt:   effOp = aluSlt;
                f3Sltu:  effOp = aluSltu;
                f3Xor:   effOp = aluXor;
                f3Srl:   effOp = instr.rType.funct7[5] ? aluSra : aluSrl;
                f3Or:    effOp = aluOr;
                default: effOp = aluAnd;
            endcase
        end
    end

    always_comb begin
        case (effOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluSll:  aluResult = opA << opB[4:0];
            aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
            aluSltu: aluResult = {31'd0, opA < opB};
            aluXor:  aluResult = opA ^ opB;
            aluSrl:  aluResult = opA >> opB[4:0];
            aluSra:  aluResult = $signed(opA) >>> opB[4:0];
            aluOr:   aluResult = opA | opB;
            default: aluResult = opA & opB;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch compare on the registered operands
    always_comb begin
        case (funct3)
            f3Beq:   branchTaken = rs1Value == rs2Value;
            f3Bne:   branchTaken = rs1Value != rs2Value;
            f3Blt:   branchTaken = $signed(rs1Value) < $signed(rs2Value);
            f3Bge:   branchTaken = $signed(rs1Value) >= $signed(rs2Value);
            f3Bltu:  branchTaken = rs1Value < rs2Value;
            f3Bgeu:  branchTaken = rs1Value >= rs2Value;
            default: branchTaken = 1'b0;
        endcase
    end

    assign nextPc = pcSel ? aluOut : aluResult;

endmodule

// File: verilog/instrFetch.sv
// program counter, memory address select, instruction and memory data registers.
`timescale 1ns/1ps

module instrFetch import rvIsaPkg::*; #(
    parameter int memWords = 256
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pcWrite,
    input  logic                        irWrite,
    input  logic                        mdrWrite,
    input  logic                        addrSel,
    input  logic [31:0]                 nextPc,
    input  logic [31:0]                 readData,
    output logic [31:0]                 pc,
    output logic [$clog2(memWords)-1:0] memAddr,
    output rvInstrT                     instr,
    output logic [31:0]                 memData
);

    localparam int addrW = $clog2(memWords);

    logic [31:0] byteAddr;

    // the read takes a cycle, so the address runs one step ahead.
    // a pc update or a data access both present the nextPc bus.
    assign byteAddr = (addrSel || pcWrite) ? nextPc : pc;
    assign memAddr  = byteAddr[addrW+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (irWrite) begin
            pc <= pc + 32'd4;  // sequential step in fetch.
        end else if (pcWrite) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) begin
            instr <= readData;
        end
        if (mdrWrite) begin
            memData <= readData;
        end
    end

    // jump and branch targets come back from the execute side.
    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

// File: verilog/registerFile.sv
// 32 x 32 register file, two asynchronous reads, one synchronous write.
`timescale 1ns/1ps

module registerFile (
    input  logic        clk,
    input  logic        writeEn,
    input  logic [4:0]  rd,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [31:0] writeData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (writeEn && rd != 5'd0) begin
            regs[rd] <= writeData;
        end
    end

    // x0 reads as zero.
    assign rs1Data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// File: verilog/rvCore.sv
// multicycle RV32I core top level with program loader and event outputs.
`timescale 1ns/1ps

module rvCore import rvIsaPkg::*; import cpuCtrlPkg::*; #(
    parameter int memWords = 256
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        run,
    input  logic                        loadEn,
    input  logic [$clog2(memWords)-1:0] loadAddr,
    input  logic [31:0]                 loadData,
    output logic                        regWrite,
    output logic [4:0]                  regAddr,
    output logic [31:0]                 regData,
    output logic                        storeValid,
    output logic [31:0]                 storeAddr,
    output logic [31:0]                 storeData
);

    logic                        pcWrite;
    logic                        irWrite;
    logic                        mdrWrite;
    logic                        addrSel;
    logic                        pcSel;
    logic                        regWriteEn;
    logic                        branchTaken;
    aluSrcAT                     aluSrcA;
    aluSrcBT                     aluSrcB;
    aluOpT                       aluOp;
    wbSelT                       wbSel;
    logic [31:0]                 pc;
    logic [31:0]                 nextPc;
    logic [31:0]                 readData;
    logic [31:0]                 memData;
    logic [31:0]                 rs1Data;
    logic [31:0]                 rs2Data;
    logic [$clog2(memWords)-1:0] memAddr;
    rvInstrT                     instr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input side
    unifiedMemory #(.memWords(memWords)) u_unifiedMemory (
        .clk(clk), .addr(memAddr), .writeEn(storeValid), .writeData(storeData),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData), .readData(readData));

    instrFetch #(.memWords(memWords)) u_instrFetch (
        .clk(clk), .reset(reset), .pcWrite(pcWrite), .irWrite(irWrite), .mdrWrite(mdrWrite),
        .addrSel(addrSel), .nextPc(nextPc), .readData(readData), .pc(pc), .memAddr(memAddr),
        .instr(instr), .memData(memData));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processing
    controlFsm u_controlFsm (
        .clk(clk), .reset(reset), .run(run), .instr(instr), .branchTaken(branchTaken),
        .pcWrite(pcWrite), .irWrite(irWrite), .mdrWrite(mdrWrite), .addrSel(addrSel),
        .memWrite(storeValid), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
        .pcSel(pcSel), .wbSel(wbSel), .regWriteEn(regWriteEn));

    registerFile u_registerFile (
        .clk(clk), .writeEn(regWrite), .rd(regAddr), .rs1(instr.rType.rs1),
        .rs2(instr.rType.rs2), .writeData(regData), .rs1Data(rs1Data), .rs2Data(rs2Data));

    execUnit u_execUnit (
        .clk(clk), .pc(pc), .instr(instr), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp), .pcSel(pcSel),
        .aluOut(storeAddr), .rs2Value(storeData), .nextPc(nextPc), .branchTaken(branchTaken));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output side
    writeBack u_writeBack (
        .wbSel(wbSel), .regWriteEn(regWriteEn), .instr(instr), .aluOut(storeAddr),
        .memData(memData), .pc(pc), .regWrite(regWrite), .regAddr(regAddr), .regData(regData));

endmodule

// File: verilog/rvIsaPkg.sv
// RV32I opcodes, funct3 codes and the instruction word formats.
package rvIsaPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // funct3, alu group
    localparam logic [2:0] f3Add  = 3'b000;  // also sub.
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Srl  = 3'b101;  // also sra.
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    // funct3, branch group
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;  // u immediate, or the scrambled j immediate.
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
    } rvInstrT;

endpackage

// File: verilog/unifiedMemory.sv
// single-port synchronous word memory with a program loader port.
`timescale 1ns/1ps

module unifiedMemory #(
    parameter int memWords = 256
) (
    input  logic                        clk,
    input  logic [$clog2(memWords)-1:0] addr,
    input  logic                        writeEn,
    input  logic [31:0]                 writeData,
    input  logic                        loadEn,
    input  logic [$clog2(memWords)-1:0] loadAddr,
    input  logic [31:0]                 loadData,
    output logic [31:0]                 readData
);

    logic [31:0] mem [memWords];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;  // loader wins.
        end else if (writeEn) begin
            mem[addr] <= writeData;
        end
        readData <= mem[addr];  // old word on a write to the same address.
    end

    // the loader is only used while the core sits in idle.
    assert property (@(posedge clk) !(loadEn && writeEn))
        else $error("loader write collides with a core store");

endmodule

// File: verilog/writeBack.sv
// register write-back source select and write strobe.
`timescale 1ns/1ps

module writeBack import rvIsaPkg::*; import cpuCtrlPkg::*; (
    input  wbSelT       wbSel,
    input  logic        regWriteEn,
    input  rvInstrT     instr,
    input  logic [31:0] aluOut,
    input  logic [31:0] memData,
    input  logic [31:0] pc,
    output logic        regWrite,
    output logic [4:0]  regAddr,
    output logic [31:0] regData
);

    assign regWrite = regWriteEn;
    assign regAddr  = instr.rType.rd;

    always_comb begin
        case (wbSel)
            wbMem:   regData = memData;
            wbPc4:   regData = pc;  // link, pc already points past the jump.
            default: regData = aluOut;
        endcase
    end

endmodule
